//--- verilog/pool_defines.svh
`ifndef POOL_DEFINES_SVH
`define POOL_DEFINES_SVH

// --------------------
// datapath sizing
// --------------------

// one stream word
`define POOL_DWID 32

// byte lanes per word, the narrowest layout
`define POOL_LANES 4

// window size, run length and element counters
`define POOL_CNT_W 8

`endif

//--- verilog/pool_pkg.sv
`default_nettype none

`include "pool_defines.svh"

package pool_pkg;

  // one stream word, viewed per lane layout
  typedef union packed {
    logic [`POOL_DWID-1:0]       w32;
    logic [1:0][15:0]            h16;
    logic [`POOL_LANES-1:0][7:0] b8;
  } vect_word_u;

  // lane layout of a word
  typedef enum logic [1:0] {
    VECT_32 = 2'b00,
    VECT_16 = 2'b01,
    VECT_8  = 2'b10
  } vect_mode_e;

  // reduction applied across a window
  typedef enum logic [1:0] {
    OP_ACC = 2'b00,
    OP_MAX = 2'b01,
    OP_MIN = 2'b10
  } pool_op_e;

  // window FSM
  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,
    ST_FIRST    = 3'd1,
    ST_ACCUM    = 3'd2,
    ST_HOLD     = 3'd3,
    ST_HOLD_END = 3'd4
  } pool_state_e;

endpackage

`default_nettype wire

//--- verilog/pool_ctrl_fsm.sv
`default_nettype none
`timescale 1ns/1ps

module pool_ctrl_fsm
  import pool_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic start_i,
  input  wire logic data_valid_i,
  input  wire logic rslt_ready_i,
  input  wire logic wind_last_i,
  input  wire logic run_last_i,
  output logic      data_ready_o,
  output logic      rslt_valid_o,
  output logic      busy_o,
  output logic      done_o,
  output logic      beat_o,
  output logic      load_first_o,
  output logic      accumulate_o,
  output logic      run_clear_o
);

  pool_state_e state_q;
  pool_state_e state_d;
  logic        done_q;

  // --------------------
  // stream handshakes
  // --------------------

  // input is open only while no result is pending
  assign data_ready_o = (state_q == ST_FIRST) || (state_q == ST_ACCUM);
  assign rslt_valid_o = (state_q == ST_HOLD) || (state_q == ST_HOLD_END);
  assign beat_o       = data_ready_o && data_valid_i;

  // result register steering
  assign load_first_o = beat_o && (state_q == ST_FIRST);
  assign accumulate_o = beat_o && (state_q == ST_ACCUM);

  // counters restart with each run
  assign run_clear_o  = (state_q == ST_IDLE) && start_i;

  assign busy_o       = (state_q != ST_IDLE);
  assign done_o       = done_q;

  // --------------------
  // next state
  // --------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start_i) begin
          state_d = ST_FIRST;
        end
      end
      ST_FIRST, ST_ACCUM: begin
        if (beat_o) begin
          if (wind_last_i) begin
            state_d = run_last_i ? ST_HOLD_END : ST_HOLD;
          end else begin
            state_d = ST_ACCUM;
          end
        end
      end
      ST_HOLD: begin
        if (rslt_ready_i) begin
          state_d = ST_FIRST;
        end
      end
      ST_HOLD_END: begin
        if (rslt_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // last result taken, pulse done once
      done_q  <= (state_q == ST_HOLD_END) && rslt_ready_i;
    end
  end

  // --------------------
  // checks
  // --------------------

  // a presented result is not withdrawn before acceptance
  a_rslt_held: assert property (@(posedge clk) disable iff (!rst_n)
    rslt_valid_o && !rslt_ready_i |=> rslt_valid_o);

endmodule

`default_nettype wire

//--- verilog/pool_wind_counter.sv
`default_nettype none
`timescale 1ns/1ps

`include "pool_defines.svh"

module pool_wind_counter (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   run_clear_i,
  input  wire logic                   beat_i,
  input  wire logic [`POOL_CNT_W-1:0] wind_size_i,
  input  wire logic [`POOL_CNT_W-1:0] data_len_i,
  output logic                        wind_last_o,
  output logic                        run_last_o
);

  // elements already taken in this window / in this run
  logic [`POOL_CNT_W-1:0] wind_cnt;
  logic [`POOL_CNT_W-1:0] run_cnt;

  assign run_last_o  = (run_cnt == data_len_i - 1'b1);

  // the run's last element also closes a short window
  assign wind_last_o = (wind_cnt == wind_size_i - 1'b1) || run_last_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wind_cnt <= '0;
      run_cnt  <= '0;
    end else if (run_clear_i) begin
      wind_cnt <= '0;
      run_cnt  <= '0;
    end else if (beat_i) begin
      run_cnt  <= run_cnt + 1'b1;
      if (wind_last_o) begin
        wind_cnt <= '0;
      end else begin
        wind_cnt <= wind_cnt + 1'b1;
      end
    end
  end

  // zero sizes would never close a window
  a_sizes_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    beat_i |-> (wind_size_i != '0) && (data_len_i != '0));

endmodule

`default_nettype wire

//--- verilog/pool_simd_alu.sv
`default_nettype none
`timescale 1ns/1ps

`include "pool_defines.svh"

module pool_simd_alu
  import pool_pkg::*;
(
  input  wire logic [`POOL_DWID-1:0] a_i,
  input  wire logic [`POOL_DWID-1:0] b_i,
  input  wire vect_mode_e            vect_i,
  input  wire logic                  sign_i,
  input  wire pool_op_e              op_i,
  output logic [`POOL_DWID-1:0]      y_o
);

  // per-lane outcome
  localparam logic [2:0] SEL_A      = 3'd0;
  localparam logic [2:0] SEL_B      = 3'd1;
  localparam logic [2:0] SEL_SUM    = 3'd2;
  localparam logic [2:0] SEL_SAT_HI = 3'd3;
  localparam logic [2:0] SEL_SAT_LO = 3'd4;

  vect_word_u a_w;
  vect_word_u b_w;
  vect_word_u b_op;
  vect_word_u sum_w;
  vect_word_u y_w;

  logic                             is_sub;
  logic [`POOL_LANES-1:0]           lane_top;
  logic [`POOL_LANES-1:0]           brk;
  logic [`POOL_LANES-1:0][1:0]      owner;
  logic [36:0]                      ext_a;
  logic [36:0]                      ext_b;
  logic [36:0]                      ext_s;
  logic [`POOL_LANES-1:0]           cout;
  logic [`POOL_LANES-1:0]           ovf_sub;
  logic [`POOL_LANES-1:0]           ovf_add;
  logic [`POOL_LANES-1:0]           a_ge_b;
  logic [`POOL_LANES-1:0][2:0]      seg_sel;

  assign a_w    = a_i;
  assign b_w    = b_i;
  // compare runs a - b, acc runs a + b
  assign is_sub = (op_i != OP_ACC);
  assign b_op   = is_sub ? ~b_i : b_i;

  // --------------------
  // lane layout
  // --------------------
  always_comb begin
    case (vect_i)
      VECT_8: begin
        lane_top = 4'b1111;
        owner    = {2'd3, 2'd2, 2'd1, 2'd0};
      end
      VECT_16: begin
        lane_top = 4'b1010;
        owner    = {2'd3, 2'd3, 2'd1, 2'd1};
      end
      default: begin
        lane_top = 4'b1000;
        owner    = {2'd3, 2'd3, 2'd3, 2'd3};
      end
    endcase
  end

  // slot below byte k breaks the chain when a lane starts at k
  assign brk = {lane_top[2:0], 1'b1};

  // --------------------
  // partitioned adder
  // --------------------
  always_comb begin
    ext_a = '0;
    ext_b = '0;
    for (int k = 0; k < `POOL_LANES; k++) begin
      // lane start: 1/1 injects carry for sub, 0/0 blocks it for add
      // inside a lane: 1/0 passes the carry through
      ext_a[9*k]        = brk[k] ? is_sub : 1'b1;
      ext_b[9*k]        = brk[k] ? is_sub : 1'b0;
      ext_a[9*k+1 +: 8] = a_w.b8[k];
      ext_b[9*k+1 +: 8] = b_op.b8[k];
    end
  end

  assign ext_s = ext_a + ext_b;

  // --------------------
  // per segment decision
  // --------------------
  always_comb begin
    for (int k = 0; k < `POOL_LANES; k++) begin
      sum_w.b8[k] = ext_s[9*k+1 +: 8];
      // slot above a lane top always breaks, so its sum bit is the carry out
      cout[k]     = ext_s[9*k+9];

      ovf_sub[k] = (a_w.b8[k][7] & ~b_w.b8[k][7] & ~sum_w.b8[k][7]) |
                   (~a_w.b8[k][7] & b_w.b8[k][7] & sum_w.b8[k][7]);
      ovf_add[k] = (a_w.b8[k][7] & b_w.b8[k][7] & ~sum_w.b8[k][7]) |
                   (~a_w.b8[k][7] & ~b_w.b8[k][7] & sum_w.b8[k][7]);

      // unsigned: no borrow means a >= b
      a_ge_b[k] = sign_i ? cout[k] : ~(sum_w.b8[k][7] ^ ovf_sub[k]);

      case (op_i)
        OP_MAX: begin
          seg_sel[k] = a_ge_b[k] ? SEL_A : SEL_B;
        end
        OP_MIN: begin
          seg_sel[k] = a_ge_b[k] ? SEL_B : SEL_A;
        end
        default: begin
          if (sign_i) begin
            seg_sel[k] = cout[k] ? SEL_SAT_HI : SEL_SUM;
          end else if (ovf_add[k]) begin
            seg_sel[k] = a_w.b8[k][7] ? SEL_SAT_LO : SEL_SAT_HI;
          end else begin
            seg_sel[k] = SEL_SUM;
          end
        end
      endcase
    end
  end

  // --------------------
  // byte assembly
  // --------------------

  // wider lanes follow the decision of their top byte
  always_comb begin
    for (int k = 0; k < `POOL_LANES; k++) begin
      case (seg_sel[owner[k]])
        SEL_A:      y_w.b8[k] = a_w.b8[k];
        SEL_B:      y_w.b8[k] = b_w.b8[k];
        SEL_SUM:    y_w.b8[k] = sum_w.b8[k];
        SEL_SAT_HI: y_w.b8[k] = (lane_top[k] && !sign_i) ? 8'h7f : 8'hff;
        SEL_SAT_LO: y_w.b8[k] = lane_top[k] ? 8'h80 : 8'h00;
        default:    y_w.b8[k] = 8'h00;
      endcase
    end
  end

  assign y_o = y_w.w32;

  // 2'b11 is the dropped complex layout
  always_comb begin
    a_vect_legal: assert (vect_i !== 2'b11);
  end

endmodule

`default_nettype wire

//--- verilog/pool_accum_reg.sv
`default_nettype none
`timescale 1ns/1ps

`include "pool_defines.svh"

module pool_accum_reg (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  load_first_i,
  input  wire logic                  accumulate_i,
  input  wire logic [`POOL_DWID-1:0] data_i,
  input  wire logic [`POOL_DWID-1:0] alu_i,
  output logic [`POOL_DWID-1:0]      rslt_o
);

  // --------------------
  // running window result
  // --------------------

  // first element starts the window as is
  // later ones fold in through the ALU
  // no beat, no change, so the presented result stays put
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rslt_o <= '0;
    end else if (load_first_i) begin
      rslt_o <= data_i;
    end else if (accumulate_i) begin
      rslt_o <= alu_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/pool_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "pool_defines.svh"

module pool_top
  import pool_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  // configuration, stable from start until done
  input  wire logic                   start_i,
  input  wire vect_mode_e             vect_i,
  input  wire logic                   sign_i,
  input  wire pool_op_e               op_i,
  input  wire logic [`POOL_CNT_W-1:0] wind_size_i,
  input  wire logic [`POOL_CNT_W-1:0] data_len_i,
  // element stream
  input  wire logic [`POOL_DWID-1:0]  data_i,
  input  wire logic                   data_valid_i,
  output logic                        data_ready_o,
  // result stream
  output logic [`POOL_DWID-1:0]       rslt_o,
  output logic                        rslt_valid_o,
  input  wire logic                   rslt_ready_i,
  // status
  output logic                        busy_o,
  output logic                        done_o
);

  logic                  beat;
  logic                  load_first;
  logic                  accumulate;
  logic                  run_clear;
  logic                  wind_last;
  logic                  run_last;
  logic [`POOL_DWID-1:0] alu_y;

  // --------------------
  // control
  // --------------------
  pool_ctrl_fsm u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .data_valid_i (data_valid_i),
    .rslt_ready_i (rslt_ready_i),
    .wind_last_i  (wind_last),
    .run_last_i   (run_last),
    .data_ready_o (data_ready_o),
    .rslt_valid_o (rslt_valid_o),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .beat_o       (beat),
    .load_first_o (load_first),
    .accumulate_o (accumulate),
    .run_clear_o  (run_clear)
  );

  pool_wind_counter u_cnt (
    .clk         (clk),
    .rst_n       (rst_n),
    .run_clear_i (run_clear),
    .beat_i      (beat),
    .wind_size_i (wind_size_i),
    .data_len_i  (data_len_i),
    .wind_last_o (wind_last),
    .run_last_o  (run_last)
  );

  // --------------------
  // datapath
  // --------------------

  // new element against the stored partial result
  pool_simd_alu u_alu (
    .a_i    (data_i),
    .b_i    (rslt_o),
    .vect_i (vect_i),
    .sign_i (sign_i),
    .op_i   (op_i),
    .y_o    (alu_y)
  );

  pool_accum_reg u_acc (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_first_i (load_first),
    .accumulate_i (accumulate),
    .data_i       (data_i),
    .alu_i        (alu_y),
    .rslt_o       (rslt_o)
  );

endmodule

`default_nettype wire

//--- dv/tb_pool_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "pool_defines.svh"

module tb_pool_top
  import pool_pkg::*;
();

  localparam int LEN_T2  = 16;
  localparam int LEN_T3  = 24;
  localparam int LEN_T4  = 8;
  localparam int LEN_T5A = 13;
  localparam int LEN_T5B = 10;
  localparam int LEN_T6  = 30;
  localparam int TOTAL_ELEMS = LEN_T2 + 2 * LEN_T3 + 6 * LEN_T4 + LEN_T5A + LEN_T5B
                               + 2 * LEN_T6;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   start;
  vect_mode_e             vect;
  logic                   sign;
  pool_op_e               op;
  logic [`POOL_CNT_W-1:0] wind_size;
  logic [`POOL_CNT_W-1:0] data_len;
  logic [`POOL_DWID-1:0]  data;
  logic                   data_valid;
  logic                   data_ready;
  logic [`POOL_DWID-1:0]  rslt;
  logic                   rslt_valid;
  logic                   rslt_ready = 1'b0;
  logic                   busy;
  logic                   done;

  logic [31:0] data_seed = 32'd57197;
  logic [31:0] ready_seed = 32'd57197 * 32'd1664525 + 32'd1013904223;
  int          data_stall_pct;
  int          rslt_stall_pct;
  logic [31:0] stim_q[$];
  logic [31:0] exp_q[$];
  int          error_count = 0;
  int          check_count = 0;
  int          result_count = 0;
  int          done_count = 0;
  int          in_win = 0;
  int          run_pos = 0;
  bit          close_pending = 0;
  bit          accept_last = 0;
  bit          in_run = 0;
  int          err_before;

  always #5 clk = ~clk;

  pool_top DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start),
    .vect_i       (vect),
    .sign_i       (sign),
    .op_i         (op),
    .wind_size_i  (wind_size),
    .data_len_i   (data_len),
    .data_i       (data),
    .data_valid_i (data_valid),
    .data_ready_o (data_ready),
    .rslt_o       (rslt),
    .rslt_valid_o (rslt_valid),
    .rslt_ready_i (rslt_ready),
    .busy_o       (busy),
    .done_o       (done)
  );

  // --------------------
  // helpers
  // --------------------
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s got %08h expected %08h", $time, name, got, exp);
    end
  endtask

  // one lane of a word as a plain number, sign extended when signed
  function automatic longint lane_value(input logic [31:0] word, input vect_mode_e vm,
                                        input int idx, input logic uns);
    vect_word_u w;
    longint     v;
    int         wd;
    w = word;
    case (vm)
      VECT_8: begin
        v  = longint'(w.b8[idx]);
        wd = 8;
      end
      VECT_16: begin
        v  = longint'(w.h16[idx]);
        wd = 16;
      end
      default: begin
        v  = longint'(w.w32);
        wd = 32;
      end
    endcase
    if (!uns && v[wd-1]) begin
      v = v - (longint'(1) << wd);
    end
    return v;
  endfunction

  // one reduction step: new element a against running result b
  function automatic logic [31:0] ref_fold(input logic [31:0] a, input logic [31:0] b,
                                           input vect_mode_e vm, input logic uns,
                                           input pool_op_e o);
    vect_word_u y;
    int         nl;
    int         wd;
    longint     va;
    longint     vb;
    longint     vr;
    longint     lo;
    longint     hi;
    y  = a;
    nl = (vm == VECT_8) ? 4 : (vm == VECT_16) ? 2 : 1;
    wd = 32 / nl;
    hi = uns ? (longint'(1) << wd) - 1 : (longint'(1) << (wd - 1)) - 1;
    lo = uns ? longint'(0) : -(longint'(1) << (wd - 1));
    for (int i = 0; i < nl; i++) begin
      va = lane_value(a, vm, i, uns);
      vb = lane_value(b, vm, i, uns);
      case (o)
        OP_MAX:  vr = (va >= vb) ? va : vb;
        OP_MIN:  vr = (va <= vb) ? va : vb;
        default: vr = va + vb;
      endcase
      // saturate at the lane limits
      if (vr > hi) vr = hi;
      if (vr < lo) vr = lo;
      case (vm)
        VECT_8:  y.b8[i] = 8'(vr);
        VECT_16: y.h16[i] = 16'(vr);
        default: y.w32 = 32'(vr);
      endcase
    end
    return y.w32;
  endfunction

  task automatic fill_random(input int n);
    stim_q.delete();
    repeat (n) begin
      data_seed = lcg_step(data_seed);
      stim_q.push_back(data_seed);
    end
  endtask

  task automatic report_test(input string name, input int errs);
    $display("test %s: %s", name, (error_count == errs) ? "ok" : "mismatches");
  endtask

  // --------------------
  // one run of the unit
  // --------------------
  task automatic run_pool(input vect_mode_e vm, input logic uns, input pool_op_e o,
                          input int wsize, input int len);
    logic [31:0] r;
    int          idx;
    int          waited;
    int          done_before;
    bit          sent;
    for (int i = 0; i < len; i += wsize) begin
      r = stim_q[i];
      for (int j = i + 1; j < i + wsize && j < len; j++) begin
        r = ref_fold(stim_q[j], r, vm, uns, o);
      end
      exp_q.push_back(r);
    end
    done_before = done_count;
    @(negedge clk);
    vect      = vm;
    sign      = uns;
    op        = o;
    wind_size = `POOL_CNT_W'(wsize);
    data_len  = `POOL_CNT_W'(len);
    start     = 1'b1;
    @(negedge clk);
    start     = 1'b0;
    idx  = 0;
    sent = 0;
    while (idx < len) begin
      @(negedge clk);
      if (sent) data_valid = 1'b0;
      if (!data_valid) begin
        data_seed = lcg_step(data_seed);
        if (((data_seed >> 16) % 100) >= data_stall_pct) begin
          data       = stim_q[idx];
          data_valid = 1'b1;
        end
      end
      @(posedge clk);
      sent = data_valid && data_ready;
      if (sent) idx++;
    end
    @(negedge clk);
    data_valid = 1'b0;
    waited = 0;
    while (done_count == done_before && waited < len * 20 + 50) begin
      @(negedge clk);
      waited++;
    end
    if (done_count == done_before) begin
      error_count++;
      $display("run of %0d elements never signalled done at %0t", len, $time);
    end
    repeat (2) @(negedge clk);
    check_value("done pulses", 32'(done_count - done_before), 32'd1);
    check_value("results left", 32'(exp_q.size()), 32'd0);
    check_value("busy_o", 32'(busy), 32'd0);
  endtask

  // --------------------
  // result stream
  // --------------------
  always @(negedge clk) begin
    ready_seed = lcg_step(ready_seed);
    rslt_ready = ((ready_seed >> 16) % 100) >= rslt_stall_pct;
  end

  // compare accepted results in order
  always @(posedge clk) begin
    if (rst_n && rslt_valid && rslt_ready) begin
      result_count++;
      if (exp_q.size() == 0) begin
        error_count++;
        $display("result %08h accepted at %0t with no window pending", rslt, $time);
      end else begin
        check_value("rslt_o", rslt, exp_q.pop_front());
      end
    end
  end

  // handshake timing, tracked from the stream itself
  always @(posedge clk) begin
    if (rst_n) begin
      // busy spans from the cycle after start to the last acceptance
      check_value("busy_o", 32'(busy), 32'(in_run));
      if (close_pending) begin
        check_value("rslt_valid_o", 32'(rslt_valid), 32'd1);
        close_pending = 0;
      end
      if (rslt_valid) begin
        check_value("data_ready_o", 32'(data_ready), 32'd0);
      end
      if (done) begin
        done_count++;
        check_value("last result before done_o", 32'(accept_last), 32'd1);
      end
      accept_last = rslt_valid && rslt_ready && (run_pos == int'(data_len));
      if (accept_last) begin
        in_run = 0;
      end
      if (start && !busy) begin
        in_win  = 0;
        run_pos = 0;
        in_run  = 1;
      end
      if (data_valid && data_ready) begin
        in_win++;
        run_pos++;
        if (in_win == int'(wind_size) || run_pos == int'(data_len)) begin
          close_pending = 1;
          in_win        = 0;
        end
      end
    end
  end

  // --------------------
  // tests
  // --------------------
  initial begin
    rst_n          = 1'b0;
    start          = 1'b0;
    vect           = VECT_8;
    sign           = 1'b0;
    op             = OP_ACC;
    wind_size      = `POOL_CNT_W'(1);
    data_len       = `POOL_CNT_W'(1);
    data           = '0;
    data_valid     = 1'b0;
    data_stall_pct = 0;
    rslt_stall_pct = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    err_before = error_count;
    @(negedge clk);
    check_value("data_ready_o", 32'(data_ready), 32'd0);
    check_value("rslt_valid_o", 32'(rslt_valid), 32'd0);
    check_value("busy_o", 32'(busy), 32'd0);
    check_value("done_o", 32'(done), 32'd0);
    report_test("reset state", err_before);

    err_before = error_count;
    fill_random(LEN_T2);
    run_pool(VECT_8, 1'b0, OP_MAX, 4, LEN_T2);
    report_test("signed max 8-bit", err_before);

    err_before = error_count;
    fill_random(LEN_T3);
    data_seed = lcg_step(data_seed);
    run_pool(VECT_16, 1'b1, OP_MIN, 1 + int'((data_seed >> 16) % 8), LEN_T3);
    fill_random(LEN_T3);
    data_seed = lcg_step(data_seed);
    run_pool(VECT_32, 1'b0, OP_MIN, 1 + int'((data_seed >> 16) % 8), LEN_T3);
    report_test("min 16 and 32-bit", err_before);

    // large operands overflow every lane layout in both directions
    err_before = error_count;
    stim_q = '{32'h9060_6090, 32'hA070_70A0, 32'h9888_8898, 32'h8123_4567,
               32'h6090_9060, 32'h7050_5070, 32'h7fff_0001, 32'h0123_4567};
    for (int s = 0; s < 2; s++) begin
      for (int l = 0; l < 3; l++) begin
        run_pool(vect_mode_e'(l), s[0], OP_ACC, 4, LEN_T4);
      end
    end
    report_test("saturating acc", err_before);

    err_before = error_count;
    fill_random(LEN_T5A);
    run_pool(VECT_16, 1'b0, OP_MAX, 4, LEN_T5A);
    fill_random(LEN_T5B);
    run_pool(VECT_8, 1'b1, OP_ACC, 1, LEN_T5B);
    report_test("short window and size 1", err_before);

    err_before = error_count;
    data_stall_pct = 40;
    rslt_stall_pct = 50;
    fill_random(LEN_T6);
    run_pool(VECT_8, 1'b0, OP_MAX, 5, LEN_T6);
    fill_random(LEN_T6);
    run_pool(VECT_16, 1'b1, OP_ACC, 3, LEN_T6);
    report_test("random back-pressure", err_before);

    $display("checks %0d, results %0d, errors %0d", check_count, result_count, error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // --------------------
  // watchdog
  // --------------------
  initial begin
    repeat (TOTAL_ELEMS * 20) @(posedge clk);
    $display("watchdog expired after %0d cycles, tests did not finish", TOTAL_ELEMS * 20);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+verilog
verilog/pool_pkg.sv
verilog/pool_ctrl_fsm.sv
verilog/pool_wind_counter.sv
verilog/pool_simd_alu.sv
verilog/pool_accum_reg.sv
verilog/pool_top.sv
dv/tb_pool_top.sv

//--- run.sh
#!/bin/sh
# builds the pooling unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module tb_pool_top -Mdir obj_dir -o sim_pool
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_pool > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" sim.log; then
  exit 1
fi
grep -q ">>> PASS" sim.log || exit 1
exit 0
